// File: hdl/backend_config.svh
`ifndef BACKEND_CONFIG_SVH
`define BACKEND_CONFIG_SVH

// datapath widths
`define DATA_W            32
`define TAG_W             6   // result tag, one per in-flight op
`define ALU_OP_W          3

// issue side
`define IQ_DEPTH          4   // entries per alu queue
`define FU_COUNT          3   // identical alu queues

// result side
`define RESULT_FIFO_DEPTH 2
`define CDB_COUNT         2   // broadcast lanes per cycle

`endif

// File: hdl/uop_pkg.sv
`default_nettype none

`include "backend_config.svh"

package uop_pkg;

    typedef enum logic [`ALU_OP_W-1:0] {
        ADD = 3'd0,
        SUB = 3'd1,
        AND = 3'd2,
        OR  = 3'd3,
        XOR = 3'd4,
        SLL = 3'd5, // shift amount from low bits of b
        SRL = 3'd6,
        SLT = 3'd7  // signed compare
    } alu_op_e;

    // layout of an operand that still waits for its producer
    typedef struct packed {
        logic [`DATA_W-`TAG_W-1:0] pad; // zero
        logic [`TAG_W-1:0]         tag; // producer tag
    } pending_t;

    // same word, value once ready, producer tag before that
    typedef union packed {
        logic [`DATA_W-1:0] value;
        pending_t           pending;
    } operand_u;

    typedef struct packed {
        logic     ready;
        operand_u u;
    } operand_t;

    typedef struct packed {
        alu_op_e           op;
        logic [`TAG_W-1:0] dst_tag;
        operand_t          a;
        operand_t          b;
    } uop_t;

endpackage

`default_nettype wire

// File: hdl/cdb_pkg.sv
`default_nettype none

`include "backend_config.svh"

package cdb_pkg;

    typedef struct packed {
        logic [`TAG_W-1:0]  tag;
        logic [`DATA_W-1:0] data;
    } cdb_entry_t;

    // capture a broadcast value into a waiting operand
    function automatic uop_pkg::operand_t snoop_operand(
        input uop_pkg::operand_t           opnd,
        input logic [`CDB_COUNT-1:0]       lane_valid,
        input cdb_entry_t [`CDB_COUNT-1:0] lanes
    );
        uop_pkg::operand_t res;
        res = opnd;
        for (int i = 0; i < `CDB_COUNT; i++) begin
            if (!opnd.ready && lane_valid[i] && lanes[i].tag == opnd.u.pending.tag) begin
                res.ready   = 1'b1;
                res.u.value = lanes[i].data; // tag word replaced by the data
            end
        end
        return res;
    endfunction

endpackage

`default_nettype wire

// File: hdl/dispatch_stage.sv
`timescale 1ns/1ps
`default_nettype none

`include "backend_config.svh"

module dispatch_stage (
    input  wire                                      clk,
    input  wire                                      reset_i,
    input  wire                                      disp_valid_i,
    input  wire uop_pkg::uop_t                       disp_uop_i,
    input  wire [`FU_COUNT-1:0]                      iq_ready_i,
    input  wire [`CDB_COUNT-1:0]                     cdb_valid_i,
    input  wire cdb_pkg::cdb_entry_t [`CDB_COUNT-1:0] cdb_entry_i,
    output logic                                     disp_ready_o,
    output logic [`FU_COUNT-1:0]                     iq_valid_o,
    output uop_pkg::uop_t                            iq_uop_o
);

localparam int PTR_W = $clog2(`FU_COUNT);

logic [PTR_W-1:0] rr_ptr_q; // queue tried first
logic [PTR_W-1:0] sel;
logic             found;
logic             fire;

// first queue with space, counting from the round-robin pointer
always_comb begin
    int idx;
    found = 1'b0;
    sel   = rr_ptr_q;
    for (int k = 0; k < `FU_COUNT; k++) begin
        idx = int'(rr_ptr_q) + k;
        if (idx >= `FU_COUNT) begin
            idx = idx - `FU_COUNT;
        end
        if (!found && iq_ready_i[idx]) begin
            found = 1'b1;
            sel   = PTR_W'(idx);
        end
    end
end

assign disp_ready_o = found;
assign fire         = disp_valid_i && found;

always_comb begin
    iq_valid_o = '0;
    if (fire) begin
        iq_valid_o[sel] = 1'b1;
    end
end

// operands whose producer is on the cdb right now would miss it in the queue
always_comb begin
    iq_uop_o   = disp_uop_i;
    iq_uop_o.a = cdb_pkg::snoop_operand(disp_uop_i.a, cdb_valid_i, cdb_entry_i);
    iq_uop_o.b = cdb_pkg::snoop_operand(disp_uop_i.b, cdb_valid_i, cdb_entry_i);
end

always_ff @(posedge clk) begin
    if (reset_i) begin
        rr_ptr_q <= '0;
    end else if (fire) begin
        // next search starts after the queue just used
        rr_ptr_q <= (sel == PTR_W'(`FU_COUNT - 1)) ? '0 : sel + 1'b1;
    end
end

endmodule

`default_nettype wire

// File: hdl/alu_issue_queue.sv
`timescale 1ns/1ps
`default_nettype none

`include "backend_config.svh"

module alu_issue_queue (
    input  wire                                      clk,
    input  wire                                      reset_i,
    input  wire                                      flush_i,
    input  wire                                      iq_valid_i,
    input  wire uop_pkg::uop_t                       iq_uop_i,
    input  wire [`CDB_COUNT-1:0]                     cdb_valid_i,
    input  wire cdb_pkg::cdb_entry_t [`CDB_COUNT-1:0] cdb_entry_i,
    input  wire                                      res_ready_i,
    output logic                                     iq_ready_o,
    output logic                                     res_valid_o,
    output cdb_pkg::cdb_entry_t                      res_entry_o
);

localparam int IDX_W = $clog2(`IQ_DEPTH);
localparam int SH_W  = $clog2(`DATA_W);

// slot 0 holds the oldest op, younger ones follow
uop_pkg::uop_t         slot_q     [`IQ_DEPTH];
logic [`IQ_DEPTH-1:0]  slot_vld_q;
uop_pkg::uop_t         woke       [`IQ_DEPTH];
uop_pkg::uop_t         slot_d     [`IQ_DEPTH];
logic [`IQ_DEPTH-1:0]  slot_vld_d;

logic [IDX_W-1:0]      issue_idx;
logic                  issue_any;
logic                  issue_fire;
uop_pkg::uop_t         issue_uop;
logic                  alu_free;

logic                  alu_vld_q;
cdb_pkg::cdb_entry_t   alu_res_q;

function automatic logic [`DATA_W-1:0] alu_calc(input uop_pkg::uop_t u);
    logic [`DATA_W-1:0] a;
    logic [`DATA_W-1:0] b;
    logic [`DATA_W-1:0] r;
    a = u.a.u.value;
    b = u.b.u.value;
    case (u.op)
        uop_pkg::ADD: r = a + b;
        uop_pkg::SUB: r = a - b;
        uop_pkg::AND: r = a & b;
        uop_pkg::OR:  r = a | b;
        uop_pkg::XOR: r = a ^ b;
        uop_pkg::SLL: r = a << b[SH_W-1:0];
        uop_pkg::SRL: r = a >> b[SH_W-1:0];
        uop_pkg::SLT: r = {{(`DATA_W-1){1'b0}}, $signed(a) < $signed(b)};
        default:      r = '0;
    endcase
    return r;
endfunction

assign iq_ready_o = !slot_vld_q[`IQ_DEPTH-1]; // last slot free means room

// stored operands listen to both cdb lanes
always_comb begin
    for (int i = 0; i < `IQ_DEPTH; i++) begin
        woke[i]   = slot_q[i];
        woke[i].a = cdb_pkg::snoop_operand(slot_q[i].a, cdb_valid_i, cdb_entry_i);
        woke[i].b = cdb_pkg::snoop_operand(slot_q[i].b, cdb_valid_i, cdb_entry_i);
    end
end

// oldest op whose operands were ready at the last edge
always_comb begin
    issue_any = 1'b0;
    issue_idx = '0;
    for (int i = 0; i < `IQ_DEPTH; i++) begin
        if (!issue_any && slot_vld_q[i] && slot_q[i].a.ready && slot_q[i].b.ready) begin
            issue_any = 1'b1;
            issue_idx = IDX_W'(i);
        end
    end
end

assign issue_uop  = slot_q[issue_idx];
assign alu_free   = !alu_vld_q || res_ready_i; // empty or drained this cycle
assign issue_fire = issue_any && alu_free;

// close the gap left by the issued op, then append the new one
always_comb begin
    logic placed;
    placed = 1'b0;
    for (int i = 0; i < `IQ_DEPTH; i++) begin
        slot_d[i]     = woke[i];
        slot_vld_d[i] = slot_vld_q[i];
    end
    if (issue_fire) begin
        for (int i = 0; i < `IQ_DEPTH - 1; i++) begin
            if (i >= int'(issue_idx)) begin
                slot_d[i]     = woke[i+1];
                slot_vld_d[i] = slot_vld_q[i+1];
            end
        end
        slot_vld_d[`IQ_DEPTH-1] = 1'b0;
    end
    if (iq_valid_i) begin
        for (int i = 0; i < `IQ_DEPTH; i++) begin
            if (!placed && !slot_vld_d[i]) begin
                slot_d[i]     = iq_uop_i; // already patched by dispatch
                slot_vld_d[i] = 1'b1;
                placed        = 1'b1;
            end
        end
    end
end

always_ff @(posedge clk) begin
    if (reset_i || flush_i) begin
        slot_vld_q <= '0;
        alu_vld_q  <= 1'b0;
    end else begin
        slot_vld_q <= slot_vld_d;
        if (issue_fire) begin
            alu_vld_q <= 1'b1;
        end else if (res_ready_i) begin
            alu_vld_q <= 1'b0;
        end
    end
end

always_ff @(posedge clk) begin
    slot_q <= slot_d;
    if (issue_fire) begin
        alu_res_q.tag  <= issue_uop.dst_tag;
        alu_res_q.data <= alu_calc(issue_uop);
    end
end

assign res_valid_o = alu_vld_q;
assign res_entry_o = alu_res_q; // held while the fifo is full

endmodule

`default_nettype wire

// File: hdl/result_fifo.sv
`timescale 1ns/1ps
`default_nettype none

`include "backend_config.svh"

module result_fifo (
    input  wire                      clk,
    input  wire                      reset_i,
    input  wire                      flush_i,
    input  wire                      wr_valid_i,
    input  wire cdb_pkg::cdb_entry_t wr_entry_i,
    input  wire                      pop_i,
    output logic                     wr_ready_o,
    output logic                     head_valid_o,
    output cdb_pkg::cdb_entry_t      head_entry_o
);

localparam int PTR_W = ($clog2(`RESULT_FIFO_DEPTH) > 0) ? $clog2(`RESULT_FIFO_DEPTH) : 1;
localparam int CNT_W = $clog2(`RESULT_FIFO_DEPTH + 1);

cdb_pkg::cdb_entry_t mem_q [`RESULT_FIFO_DEPTH];
logic [PTR_W-1:0]    wr_ptr_q;
logic [PTR_W-1:0]    rd_ptr_q;
logic [CNT_W-1:0]    count_q;
logic                push;
logic                pop;

function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] p);
    return (p == PTR_W'(`RESULT_FIFO_DEPTH - 1)) ? '0 : p + 1'b1;
endfunction

assign wr_ready_o   = (count_q != CNT_W'(`RESULT_FIFO_DEPTH));
assign head_valid_o = (count_q != '0);
assign head_entry_o = mem_q[rd_ptr_q]; // no bypass from the write side
assign push         = wr_valid_i && wr_ready_o;
assign pop          = pop_i && head_valid_o;

always_ff @(posedge clk) begin
    if (reset_i || flush_i) begin
        wr_ptr_q <= '0;
        rd_ptr_q <= '0;
        count_q  <= '0;
    end else begin
        if (push) begin
            wr_ptr_q <= ptr_inc(wr_ptr_q);
        end
        if (pop) begin
            rd_ptr_q <= ptr_inc(rd_ptr_q);
        end
        if (push && !pop) begin
            count_q <= count_q + 1'b1;
        end else if (pop && !push) begin
            count_q <= count_q - 1'b1;
        end
    end
end

always_ff @(posedge clk) begin
    if (push) begin
        mem_q[wr_ptr_q] <= wr_entry_i;
    end
end

endmodule

`default_nettype wire

// File: hdl/cdb_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

`include "backend_config.svh"

module cdb_arbiter (
    input  wire                                      clk,
    input  wire                                      reset_i,
    input  wire                                      flush_i,
    input  wire [`FU_COUNT-1:0]                      head_valid_i,
    input  wire cdb_pkg::cdb_entry_t [`FU_COUNT-1:0]  head_entry_i,
    output logic [`FU_COUNT-1:0]                     pop_o,
    output logic [`CDB_COUNT-1:0]                    cdb_valid_o,
    output cdb_pkg::cdb_entry_t [`CDB_COUNT-1:0]      cdb_entry_o
);

localparam int PTR_W = $clog2(`FU_COUNT);

logic [PTR_W-1:0]                    prio_q; // unit with highest priority
logic [PTR_W-1:0]                    last_d;
logic [`CDB_COUNT-1:0]               lane_vld_d;
cdb_pkg::cdb_entry_t [`CDB_COUNT-1:0] lane_ent_d;
logic                                granted;

// walk the units from the pointer, fill lanes in grant order
always_comb begin
    int idx;
    int n;
    pop_o      = '0;
    lane_vld_d = '0;
    lane_ent_d = '0;
    last_d     = prio_q;
    n          = 0;
    for (int k = 0; k < `FU_COUNT; k++) begin
        idx = int'(prio_q) + k;
        if (idx >= `FU_COUNT) begin
            idx = idx - `FU_COUNT;
        end
        if (head_valid_i[idx] && n < `CDB_COUNT) begin
            pop_o[idx]    = 1'b1;
            lane_vld_d[n] = 1'b1;
            lane_ent_d[n] = head_entry_i[idx];
            last_d        = PTR_W'(idx);
            n             = n + 1;
        end
    end
end

assign granted = |pop_o;

always_ff @(posedge clk) begin
    if (reset_i || flush_i) begin
        prio_q      <= '0;
        cdb_valid_o <= '0;
    end else begin
        cdb_valid_o <= lane_vld_d;
        if (granted) begin
            // skip past the last unit served
            prio_q <= (last_d == PTR_W'(`FU_COUNT - 1)) ? '0 : last_d + 1'b1;
        end
    end
end

always_ff @(posedge clk) begin
    cdb_entry_o <= lane_ent_d;
end

endmodule

`default_nettype wire

// File: hdl/backend_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "backend_config.svh"

module backend_top (
    input  wire                                 clk,
    input  wire                                 reset_i,
    input  wire                                 flush_i,
    input  wire                                 disp_valid_i,
    input  wire uop_pkg::uop_t                  disp_uop_i,
    output logic                                disp_ready_o,
    output logic [`CDB_COUNT-1:0]               cdb_valid_o,
    output cdb_pkg::cdb_entry_t [`CDB_COUNT-1:0] cdb_entry_o
);

logic [`FU_COUNT-1:0]                iq_valid;
logic [`FU_COUNT-1:0]                iq_ready;
uop_pkg::uop_t                       iq_uop;   // shared, valid picks the queue

logic [`FU_COUNT-1:0]                res_valid;
logic [`FU_COUNT-1:0]                res_ready;
cdb_pkg::cdb_entry_t [`FU_COUNT-1:0] res_entry;

logic [`FU_COUNT-1:0]                head_valid;
logic [`FU_COUNT-1:0]                pop;
cdb_pkg::cdb_entry_t [`FU_COUNT-1:0] head_entry;

dispatch_stage dispatch_inst (
    .clk(clk),
    .reset_i(reset_i),
    .disp_valid_i(disp_valid_i),
    .disp_uop_i(disp_uop_i),
    .iq_ready_i(iq_ready),
    .cdb_valid_i(cdb_valid_o), // same-cycle patch
    .cdb_entry_i(cdb_entry_o),
    .disp_ready_o(disp_ready_o),
    .iq_valid_o(iq_valid),
    .iq_uop_o(iq_uop)
);

for (genvar i = 0; i < `FU_COUNT; i++) begin : g_fu
    alu_issue_queue alu_iq (
        .clk(clk),
        .reset_i(reset_i),
        .flush_i(flush_i),
        .iq_valid_i(iq_valid[i]),
        .iq_uop_i(iq_uop),
        .cdb_valid_i(cdb_valid_o),
        .cdb_entry_i(cdb_entry_o),
        .res_ready_i(res_ready[i]),
        .iq_ready_o(iq_ready[i]),
        .res_valid_o(res_valid[i]),
        .res_entry_o(res_entry[i])
    );

    // also the pipeline register in front of the cdb
    result_fifo alu_iq_fifo (
        .clk(clk),
        .reset_i(reset_i),
        .flush_i(flush_i),
        .wr_valid_i(res_valid[i]),
        .wr_entry_i(res_entry[i]),
        .pop_i(pop[i]),
        .wr_ready_o(res_ready[i]),
        .head_valid_o(head_valid[i]),
        .head_entry_o(head_entry[i])
    );
end

cdb_arbiter cdb_arbiter_inst (
    .clk(clk),
    .reset_i(reset_i),
    .flush_i(flush_i),
    .head_valid_i(head_valid),
    .head_entry_i(head_entry),
    .pop_o(pop),
    .cdb_valid_o(cdb_valid_o),
    .cdb_entry_o(cdb_entry_o)
);

endmodule

`default_nettype wire

// File: testbench/tb_backend_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "backend_config.svh"

module tb_backend_top;

localparam int NUM_OPS = 64; // one per tag
localparam int LIMIT   = NUM_OPS * 20 + 200;

logic                                 clk;
logic                                 reset_i;
logic                                 flush_i;
logic                                 disp_valid_i;
uop_pkg::uop_t                        disp_uop_i;
logic                                 disp_ready_o;
logic [`CDB_COUNT-1:0]                cdb_valid_o;
cdb_pkg::cdb_entry_t [`CDB_COUNT-1:0] cdb_entry_o;

integer             seed;
int                 cycle;
int                 accepted_cnt;
int                 seen_cnt;
int                 cancelled_cnt;
bit                 saw_stall;
bit                 clear_prev;
int                 op_code   [NUM_OPS];
int                 prod_a    [NUM_OPS]; // -1 when operand is a plain value
int                 prod_b    [NUM_OPS];
logic [`DATA_W-1:0] a_val     [NUM_OPS];
logic [`DATA_W-1:0] b_val     [NUM_OPS];
logic [`DATA_W-1:0] exp_data  [NUM_OPS];
bit                 in_flight [NUM_OPS];
bit                 bcast     [NUM_OPS];
int                 done_cyc  [NUM_OPS]; // cycle the tag was seen on the cdb

backend_top dut0 (
    .clk(clk),
    .reset_i(reset_i),
    .flush_i(flush_i),
    .disp_valid_i(disp_valid_i),
    .disp_uop_i(disp_uop_i),
    .disp_ready_o(disp_ready_o),
    .cdb_valid_o(cdb_valid_o),
    .cdb_entry_o(cdb_entry_o)
);

initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
end

task automatic fail_stop(input string why);
    $display("%s", why);
    $display("CHECKS FAILED");
    $fatal(1, "stopped at first error");
endtask

a_lane_tags_distinct: assert property (@(posedge clk) (&cdb_valid_o) |->
        (cdb_entry_o[0].tag != cdb_entry_o[1].tag))
    else fail_stop("both CDB lanes carry the same tag");
a_flush_quiet: assert property (@(posedge clk) disable iff (reset_i) flush_i |=>
        (cdb_valid_o == '0))
    else fail_stop("CDB still valid in the cycle after a flush");
a_ready_after_clear: assert property (@(posedge clk) (reset_i || flush_i) |=> disp_ready_o)
    else fail_stop("dispatch not ready in the cycle after reset or flush");

// opcode rules: shifts by low 5 bits of b, slt signed
function automatic logic [`DATA_W-1:0] model_alu(input int op, input logic [`DATA_W-1:0] a,
                                                 input logic [`DATA_W-1:0] b);
    logic [`DATA_W-1:0] r;
    case (op)
        0:       r = a + b;
        1:       r = a - b;
        2:       r = a & b;
        3:       r = a | b;
        4:       r = a ^ b;
        5:       r = a << b[4:0];
        6:       r = a >> b[4:0];
        default: r = ($signed(a) < $signed(b)) ? 1 : 0;
    endcase
    return r;
endfunction

// a producer on the cdb right now stays pending, dispatch patches it
function automatic uop_pkg::operand_t make_operand(input int prod, input logic [`DATA_W-1:0] v);
    uop_pkg::operand_t o;
    o = '0;
    if (prod < 0) begin
        o.ready   = 1'b1;
        o.u.value = v;
    end else if (bcast[prod] && done_cyc[prod] != cycle) begin
        o.ready   = 1'b1;
        o.u.value = exp_data[prod]; // producer seen on the cdb in an earlier cycle
    end else begin
        o.u.pending.tag = `TAG_W'(prod);
    end
    return o;
endfunction

task automatic observe_lanes();
    int t;
    for (int l = 0; l < `CDB_COUNT; l++) begin
        if (cdb_valid_o[l]) begin
            t = int'(cdb_entry_o[l].tag);
            assert (in_flight[t])
                else fail_stop($sformatf("tag %h broadcast while not in flight", t));
            assert (!((prod_a[t] >= 0 && !bcast[prod_a[t]]) ||
                      (prod_b[t] >= 0 && !bcast[prod_b[t]])))
                else fail_stop($sformatf("tag %h broadcast before its producer", t));
            assert (cdb_entry_o[l].data === exp_data[t])
                else fail_stop($sformatf("Fail cdb_entry_o[%0d].data tag %h: got %h expected %h",
                                         l, t, cdb_entry_o[l].data, exp_data[t]));
        end
    end
    for (int l = 0; l < `CDB_COUNT; l++) begin
        if (cdb_valid_o[l]) begin
            t            = int'(cdb_entry_o[l].tag);
            in_flight[t] = 1'b0;
            bcast[t]     = 1'b1;
            done_cyc[t]  = cycle;
            seen_cnt++;
        end
    end
endtask

// one cycle, outputs sampled at the falling edge
task automatic tick();
    bit clear_now;
    @(negedge clk);
    cycle++;
    if (cycle > LIMIT)
        fail_stop($sformatf("timeout, run went past %0d cycles", LIMIT));
    clear_now = reset_i || flush_i;
    if (clear_now || clear_prev) begin
        assert (cdb_valid_o === '0)
            else fail_stop($sformatf("Fail cdb_valid_o: got %h expected %h", cdb_valid_o, 2'h0));
        assert (disp_ready_o === 1'b1)
            else fail_stop($sformatf("Fail disp_ready_o: got %h expected %h",
                                     disp_ready_o, 1'b1));
    end
    clear_prev = clear_now;
    observe_lanes();
endtask

task automatic send_op(input int t);
    bit            taken;
    uop_pkg::uop_t u;
    taken = 1'b0;
    while (!taken) begin
        u.op         = uop_pkg::alu_op_e'(op_code[t][2:0]);
        u.dst_tag    = `TAG_W'(t);
        u.a          = make_operand(prod_a[t], a_val[t]);
        u.b          = make_operand(prod_b[t], b_val[t]);
        disp_uop_i   = u;
        disp_valid_i = 1'b1;
        taken        = disp_ready_o; // ready depends on queue state only
        if (taken) begin
            in_flight[t] = 1'b1;
            accepted_cnt++;
        end else begin
            saw_stall = 1'b1;
        end
        tick();
    end
endtask

task automatic run_ops(input int first, input int count, input bit chain, input bit fan_out);
    int                 t;
    logic [31:0]        rnd;
    logic [`DATA_W-1:0] a_eff;
    logic [`DATA_W-1:0] b_eff;
    for (int n = 0; n < count; n++) begin
        t           = first + n;
        rnd         = $random(seed);
        op_code[t]  = (t < 8) ? t : int'(rnd[2:0]); // first eight cover every op
        a_val[t]    = $random(seed);
        b_val[t]    = $random(seed);
        prod_a[t]   = -1;
        prod_b[t]   = -1;
        if (n > 0 && in_flight[t-1] && (chain || rnd[3]))
            prod_a[t] = t - 1;
        if (fan_out && n > 0 && n < 5)
            prod_a[t] = first; // followers in several queues share one producer
        if (n > 1 && in_flight[t-2] && rnd[4])
            prod_b[t] = t - 2;
        a_eff       = (prod_a[t] >= 0) ? exp_data[prod_a[t]] : a_val[t];
        b_eff       = (prod_b[t] >= 0) ? exp_data[prod_b[t]] : b_val[t];
        exp_data[t] = model_alu(op_code[t], a_eff, b_eff);
        send_op(t);
    end
    disp_valid_i = 1'b0;
endtask

task automatic wait_drain();
    while (accepted_cnt != seen_cnt + cancelled_cnt) begin
        tick();
    end
endtask

initial begin
    seed         = 32'h48a54c04;
    reset_i      = 1'b1;
    flush_i      = 1'b0;
    disp_valid_i = 1'b0;
    disp_uop_i   = '0;
    for (int t = 0; t < NUM_OPS; t++) begin
        in_flight[t] = 1'b0;
        bcast[t]     = 1'b0;
    end
    repeat (4) tick();
    reset_i = 1'b0;

    run_ops(0, 40, 1'b1, 1'b0); // dependency chain, longer than all queues together
    wait_drain();
    assert (saw_stall)
        else fail_stop("disp_ready_o never went low during the burst");

    run_ops(40, 8, 1'b1, 1'b1);
    flush_i = 1'b1;
    for (int t = 0; t < NUM_OPS; t++) begin
        if (in_flight[t]) begin
            in_flight[t] = 1'b0; // any later broadcast of these is an error
            cancelled_cnt++;
        end
    end
    tick();
    flush_i = 1'b0;

    run_ops(48, 16, 1'b0, 1'b0);
    wait_drain();
    repeat (10) tick(); // late duplicates would show up here

    if (accepted_cnt == NUM_OPS && accepted_cnt == seen_cnt + cancelled_cnt) begin
        $display("ALL CHECKS PASSED");
        $finish;
    end else begin
        fail_stop("not every operation was accepted and then broadcast");
    end
end

endmodule

`default_nettype wire

// File: compile.f
+incdir+hdl
hdl/uop_pkg.sv
hdl/cdb_pkg.sv
hdl/dispatch_stage.sv
hdl/alu_issue_queue.sv
hdl/result_fifo.sv
hdl/cdb_arbiter.sv
hdl/backend_top.sv
testbench/tb_backend_top.sv

// File: run.sh
#!/bin/sh
# build the backend testbench with Verilator, run it and scan the log
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -f compile.f --top-module tb_backend_top \
    -o tb_sim > build.log 2>&1 || { cat build.log; echo "build failed"; exit 1; }
./obj_dir/tb_sim > sim.log 2>&1 || true
cat sim.log
grep -q "CHECKS FAILED" sim.log && { echo "simulation failed"; exit 1; }
grep -q "ALL CHECKS PASSED" sim.log || { echo "simulation did not finish"; exit 1; }
exit 0
